//--- fpgaSer_defs.svh
`ifndef FPGA_SER_DEFS_SVH
`define FPGA_SER_DEFS_SVH

////////////////////
// pc link word
////////////////////

// code field in front of every pc word
`define PC_CODE_W 7
// payload bits per pc word
`define PC_DATA_W 20

////////////////////
// sources
////////////////////

// wall clock from the time manager
`define TIME_FULL_W 48
// time bits actually sent up, two payloads worth
`define TIME_W 40
// spike filter record fields
`define SF_FILT_W 10
`define SF_STATE_W 27

`endif

//--- pcLinkPkg.sv
`default_nettype none

`include "fpgaSer_defs.svh"

package pcLinkPkg;

  ////////////////////
  // word codes
  ////////////////////

  // codes seen by the host, one per word kind
  typedef enum logic [`PC_CODE_W-1:0] {
    SF_CODE     = `PC_CODE_W'd14,
    // time low half
    HB_LSB_CODE = `PC_CODE_W'd15,
    // time high half
    HB_MSB_CODE = `PC_CODE_W'd16
  } pcCode_e;

  // one word on the pc port
  typedef struct packed {
    logic [`PC_CODE_W-1:0] code;
    logic [`PC_DATA_W-1:0] payload;
  } pcWord_t;

  ////////////////////
  // fsm states
  ////////////////////

  // serializer, waiting for an item or sending its words
  typedef enum logic {
    SER_IDLE,
    SER_SEND
  } serState_e;

  // merge grant and round-robin pointer
  typedef enum logic {
    SRC_SF,
    SRC_HB
  } mergeSrc_e;

endpackage

`default_nettype wire

//--- spikePkg.sv
`default_nettype none

`include "fpgaSer_defs.svh"

package spikePkg;

  ////////////////////
  // spike filter
  ////////////////////

  // record from the spike filters
  // filter index sits above the state so the state goes out first
  typedef struct packed {
    logic [`SF_FILT_W-1:0]  filtIdx;
    logic [`SF_STATE_W-1:0] filtState;
  } sfRecord_t;

  ////////////////////
  // heartbeat
  ////////////////////

  // kept time split in two halves
  // each half carries a flag on top so the coder knows which one it is
  typedef struct packed {
    // always 1, marks the high half
    logic                  msbFlag;
    logic [`PC_DATA_W-1:0] timeHi;
    // always 0, marks the low half
    logic                  lsbFlag;
    logic [`PC_DATA_W-1:0] timeLo;
  } hbPacked_t;

endpackage

`default_nettype wire

//--- pulseToChannel.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpgaSer_defs.svh"

module pulseToChannel (
  input  wire logic                    clk,
  input  wire logic                    rst,
  // one cycle strobe from the time manager
  input  wire logic                    pulse,
  input  wire logic [`TIME_FULL_W-1:0] timeIn,
  output logic      [`TIME_FULL_W-1:0] item,
  output logic                         valid,
  input  wire logic                    ready
);

  // one entry hold register
  logic                    full;
  logic [`TIME_FULL_W-1:0] timeHold;

  // occupancy
  // a pulse landing while full is simply lost
  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
    end else if (valid && ready) begin
      full <= 1'b0;
    end else if (pulse && !full) begin
      full <= 1'b1;
    end
  end

  // time sample, only taken into an empty register
  always_ff @(posedge clk) begin
    if (pulse && !full) begin
      timeHold <= timeIn;
    end
  end

  // held item toward the serializer
  assign item  = timeHold;
  assign valid = full;

endmodule

`default_nettype wire

//--- serializer.sv
`timescale 1ns/1ps
`default_nettype none

module serializer #(
  parameter int Nin  = 42,
  parameter int Nout = 21
) (
  input  wire logic            clk,
  input  wire logic            rst,
  // wide item side
  input  wire logic [Nin-1:0]  inData,
  input  wire logic            inValid,
  output logic                 inReady,
  // narrow word side
  output logic      [Nout-1:0] outData,
  output logic                 outValid,
  input  wire logic            outReady
);

  ////////////////////
  // sizing
  ////////////////////

  // words per item, rounded up
  localparam int NumWords = (Nin + Nout - 1) / Nout;
  // item padded up to a whole number of words
  localparam int ShiftW   = NumWords * Nout;
  // counter needs at least one bit
  localparam int CntW     = (NumWords > 1) ? $clog2(NumWords) : 1;
  localparam logic [CntW-1:0] LastWord = CntW'(NumWords - 1);

  // a word wider than the item makes no sense here
  if (Nout > Nin) begin : gBadWidth
    $error("serializer output wider than its input");
  end

  ////////////////////
  // state
  ////////////////////

  pcLinkPkg::serState_e state;
  logic [CntW-1:0]      wordCnt;
  // item being sent, current word in the low bits
  logic [ShiftW-1:0]    shiftReg;

  // control
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= pcLinkPkg::SER_IDLE;
      wordCnt <= '0;
    end else begin
      case (state)
        pcLinkPkg::SER_IDLE: begin
          // accept a new item, first word shows up next cycle
          if (inValid) begin
            state   <= pcLinkPkg::SER_SEND;
            wordCnt <= '0;
          end
        end
        pcLinkPkg::SER_SEND: begin
          if (outReady) begin
            // last word gone, free for the next item
            if (wordCnt == LastWord) begin
              state   <= pcLinkPkg::SER_IDLE;
              wordCnt <= '0;
            end else begin
              wordCnt <= wordCnt + 1'b1;
            end
          end
        end
        default: begin
          state <= pcLinkPkg::SER_IDLE;
        end
      endcase
    end
  end

  // payload
  // load zero extends, every accepted word shifts the next one down
  always_ff @(posedge clk) begin
    if (inValid && inReady) begin
      shiftReg <= ShiftW'(inData);
    end else if (outValid && outReady) begin
      shiftReg <= shiftReg >> Nout;
    end
  end

  ////////////////////
  // handshakes
  ////////////////////

  // only takes an item with nothing in flight
  assign inReady  = (state == pcLinkPkg::SER_IDLE);
  assign outValid = (state == pcLinkPkg::SER_SEND);
  // lowest chunk first
  assign outData  = shiftReg[Nout-1:0];

endmodule

`default_nettype wire

//--- channelMerge.sv
`timescale 1ns/1ps
`default_nettype none

module channelMerge (
  input  wire logic              clk,
  input  wire logic              rst,
  // spike filter words
  input  wire pcLinkPkg::pcWord_t sfWord,
  input  wire logic              sfValid,
  output logic                   sfReady,
  // heartbeat words
  input  wire pcLinkPkg::pcWord_t hbWord,
  input  wire logic              hbValid,
  output logic                   hbReady,
  // merged stream to the pc
  output pcLinkPkg::pcWord_t     outWord,
  output logic                   outValid,
  input  wire logic              outReady
);

  // source to favour on the next contest
  pcLinkPkg::mergeSrc_e rrPtr;
  // source held while its word sits unaccepted
  pcLinkPkg::mergeSrc_e lockSrc;
  logic                 isLocked;
  // source driving the output this cycle
  pcLinkPkg::mergeSrc_e grant;

  ////////////////////
  // grant
  ////////////////////

  always_comb begin
    if (isLocked) begin
      // stalled word keeps its slot
      grant = lockSrc;
    end else if (sfValid && hbValid) begin
      grant = rrPtr;
    end else if (hbValid) begin
      grant = pcLinkPkg::SRC_HB;
    end else begin
      // also the idle choice
      grant = pcLinkPkg::SRC_SF;
    end
  end

  // output mux, purely combinational
  assign outWord  = (grant == pcLinkPkg::SRC_HB) ? hbWord : sfWord;
  assign outValid = (grant == pcLinkPkg::SRC_HB) ? hbValid : sfValid;

  // only the granted side sees the pc ready
  assign sfReady = (grant == pcLinkPkg::SRC_SF) && outReady;
  assign hbReady = (grant == pcLinkPkg::SRC_HB) && outReady;

  ////////////////////
  // pointer and lock
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      rrPtr    <= pcLinkPkg::SRC_SF;
      lockSrc  <= pcLinkPkg::SRC_SF;
      isLocked <= 1'b0;
    end else if (outValid && outReady) begin
      // hand the next contest to the other side
      rrPtr    <= (grant == pcLinkPkg::SRC_SF) ? pcLinkPkg::SRC_HB : pcLinkPkg::SRC_SF;
      isLocked <= 1'b0;
    end else if (outValid) begin
      // pc stalled, pin the grant until the word leaves
      lockSrc  <= grant;
      isLocked <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- fpgaSerializer.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpgaSer_defs.svh"

module fpgaSerializer (
  input  wire logic                    clk,
  input  wire logic                    rst,
  // time manager
  input  wire logic                    hbPulse,
  input  wire logic [`TIME_FULL_W-1:0] timeElapsed,
  // spike filters
  input  wire spikePkg::sfRecord_t     sfRecord,
  input  wire logic                    sfValid,
  output logic                         sfReady,
  // pc link
  output pcLinkPkg::pcWord_t           pcWord,
  output logic                         pcValid,
  input  wire logic                    pcReady
);

  // time packing below assumes two payloads of kept time
  if (`TIME_W != 2 * `PC_DATA_W) begin : gBadTime
    $error("kept time must fill exactly two payloads");
  end

  // heartbeat path
  logic [`TIME_FULL_W-1:0] hbFullTime;
  logic                    hbFullValid;
  logic                    hbFullReady;
  spikePkg::hbPacked_t     hbPacked;
  // one extra bit carries the half flag
  logic [`PC_DATA_W:0]     hbSerWord;
  logic                    hbSerValid;
  logic                    hbSerReady;
  pcLinkPkg::pcWord_t      hbCoded;

  // spike filter path
  logic [`PC_DATA_W-1:0]   sfSerWord;
  logic                    sfSerValid;
  logic                    sfSerReady;
  pcLinkPkg::pcWord_t      sfCoded;

  ////////////////////
  // heartbeat
  ////////////////////

  // pulse into a held channel item
  pulseToChannel hbPulseToChannel (
    .clk    (clk),
    .rst    (rst),
    .pulse  (hbPulse),
    .timeIn (timeElapsed),
    .item   (hbFullTime),
    .valid  (hbFullValid),
    .ready  (hbFullReady)
  );

  // drop the top time bits, flag each half
  always_comb begin
    hbPacked.msbFlag = 1'b1;
    hbPacked.timeHi  = hbFullTime[`TIME_W-1:`PC_DATA_W];
    hbPacked.lsbFlag = 1'b0;
    hbPacked.timeLo  = hbFullTime[`PC_DATA_W-1:0];
  end

  // low half goes out first
  serializer #(
    .Nin  ($bits(spikePkg::hbPacked_t)),
    .Nout (`PC_DATA_W + 1)
  ) hbSerializer (
    .clk      (clk),
    .rst      (rst),
    .inData   (hbPacked),
    .inValid  (hbFullValid),
    .inReady  (hbFullReady),
    .outData  (hbSerWord),
    .outValid (hbSerValid),
    .outReady (hbSerReady)
  );

  // half flag picks the code
  always_comb begin
    if (hbSerWord[`PC_DATA_W]) begin
      hbCoded.code = pcLinkPkg::HB_MSB_CODE;
    end else begin
      hbCoded.code = pcLinkPkg::HB_LSB_CODE;
    end
    hbCoded.payload = hbSerWord[`PC_DATA_W-1:0];
  end

  ////////////////////
  // spike filter
  ////////////////////

  // record goes straight in, second word zero extended
  serializer #(
    .Nin  ($bits(spikePkg::sfRecord_t)),
    .Nout (`PC_DATA_W)
  ) sfSerializer (
    .clk      (clk),
    .rst      (rst),
    .inData   (sfRecord),
    .inValid  (sfValid),
    .inReady  (sfReady),
    .outData  (sfSerWord),
    .outValid (sfSerValid),
    .outReady (sfSerReady)
  );

  // both words share one code
  always_comb begin
    sfCoded.code    = pcLinkPkg::SF_CODE;
    sfCoded.payload = sfSerWord;
  end

  ////////////////////
  // merge
  ////////////////////

  channelMerge codedMerge (
    .clk      (clk),
    .rst      (rst),
    .sfWord   (sfCoded),
    .sfValid  (sfSerValid),
    .sfReady  (sfSerReady),
    .hbWord   (hbCoded),
    .hbValid  (hbSerValid),
    .hbReady  (hbSerReady),
    .outWord  (pcWord),
    .outValid (pcValid),
    .outReady (pcReady)
  );

endmodule

`default_nettype wire

//--- fpgaSerializer_sva.sv
`timescale 1ns/1ps
`default_nettype none

module fpgaSerializer_sva (
  input wire logic               clk,
  input wire logic               rst,
  input wire pcLinkPkg::pcWord_t pcWord,
  input wire logic               pcValid,
  input wire logic               pcReady
);

  // number of failed checks so far
  int failCount = 0;

  ////////////////////
  // pc port handshake
  ////////////////////

  // stalled word and its valid stay frozen
  property pStallHold;
    @(posedge clk) disable iff (rst)
      (pcValid && !pcReady) |=> (pcValid && $stable(pcWord));
  endproperty

  // nothing offered right out of reset
  property pResetIdle;
    @(posedge clk) rst |=> !pcValid;
  endproperty

  // only the three known codes ever show up
  property pCodeLegal;
    @(posedge clk) disable iff (rst)
      pcWord.code inside {pcLinkPkg::SF_CODE, pcLinkPkg::HB_LSB_CODE, pcLinkPkg::HB_MSB_CODE};
  endproperty

  aStallHold: assert property (pStallHold)
    else begin
      failCount++;
      $error("pc word or valid changed during a stall");
    end
  aResetIdle: assert property (pResetIdle)
    else begin
      failCount++;
      $error("pc valid high in the cycle after reset");
    end
  aCodeLegal: assert property (pCodeLegal)
    else begin
      failCount++;
      $error("pc word carries an unknown code");
    end

endmodule

// attach to every top level instance
bind fpgaSerializer fpgaSerializer_sva fpgaSerializer_sva_inst (
  .clk     (clk),
  .rst     (rst),
  .pcWord  (pcWord),
  .pcValid (pcValid),
  .pcReady (pcReady)
);

`default_nettype wire

//--- tb_fpgaSerializer.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpgaSer_defs.svh"

module tb_fpgaSerializer;

  logic                    clk;
  logic                    rst;
  logic                    hbPulse;
  logic [`TIME_FULL_W-1:0] timeElapsed;
  spikePkg::sfRecord_t     sfRecord;
  logic                    sfValid;
  logic                    sfReady;
  pcLinkPkg::pcWord_t      pcWord;
  logic                    pcValid;
  logic                    pcReady;

  // expected words per source with the oldest first
  pcLinkPkg::pcWord_t sfQ[$];
  pcLinkPkg::pcWord_t hbQ[$];
  logic [31:0] lfsrState;
  logic [63:0] rVal;
  logic        sfEnable, hbEnable, readyRandom, hbBusy, sfGot, hbGot;
  int          sfSent, hbSent, sfWait, hbWait, hbGap;
  string       testName;

  fpgaSerializer fpgaSerializer_inst (
    .clk (clk), .rst (rst), .hbPulse (hbPulse), .timeElapsed (timeElapsed),
    .sfRecord (sfRecord), .sfValid (sfValid), .sfReady (sfReady),
    .pcWord (pcWord), .pcValid (pcValid), .pcReady (pcReady)
  );

  always #20 clk = ~clk;

  ////////////////////
  // helpers
  ////////////////////

  // galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // one step per bit taken
  function automatic logic [63:0] randBits(input int n);
    logic [63:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      v = {v[62:0], lfsrState[0]};
    end
    return v;
  endfunction

  function automatic pcLinkPkg::pcWord_t makeWord(input pcLinkPkg::pcCode_e c,
                                                  input logic [`PC_DATA_W-1:0] p);
    pcLinkPkg::pcWord_t w;
    w.code    = c;
    w.payload = p;
    return w;
  endfunction

  task automatic stopOnError(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic checkWord(input string name, input pcLinkPkg::pcWord_t expW,
                           input pcLinkPkg::pcWord_t actW);
    if (actW !== expW) begin
      stopOnError($sformatf("ERR %s expected code=%0d payload=%05h actual code=%0d payload=%05h",
                            name, expW.code, expW.payload, actW.code, actW.payload));
    end
  endtask

  task automatic checkFlag(input string name, input logic expF, input logic actF);
    if (actF !== expF) begin
      stopOnError($sformatf("ERR %s expected %b actual %b", name, expF, actF));
    end
  endtask

  // received word goes to the front of its own source queue
  task automatic routeWord(input pcLinkPkg::pcWord_t w);
    pcLinkPkg::pcWord_t expW;
    if (w.code == pcLinkPkg::SF_CODE) begin
      if (sfQ.size() == 0) begin
        stopOnError("a spike filter word arrived with none expected");
      end else begin
        expW = sfQ.pop_front();
        checkWord(testName, expW, w);
        sfGot = 1'b1;
      end
    end else if (w.code == pcLinkPkg::HB_LSB_CODE || w.code == pcLinkPkg::HB_MSB_CODE) begin
      if (hbQ.size() == 0) begin
        stopOnError("a heartbeat word arrived with none expected");
      end else begin
        expW = hbQ.pop_front();
        checkWord(testName, expW, w);
        hbGot = 1'b1;
        // high half closes the heartbeat
        if (w.code == pcLinkPkg::HB_MSB_CODE) begin
          hbBusy = 1'b0;
        end
      end
    end else begin
      stopOnError("a word with an unknown code arrived");
    end
  endtask

  task automatic waitForCounts(input int sfTarget, input int hbTarget, input int limit);
    int cnt;
    cnt = 0;
    while (sfSent < sfTarget || hbSent < hbTarget) begin
      @(posedge clk);
      cnt++;
      if (cnt > limit) begin
        stopOnError("timeout while waiting for the sources to send their items");
      end
    end
  endtask

  task automatic waitForDrain(input int limit);
    int cnt;
    cnt = 0;
    // one edge so a last drive is visible
    @(posedge clk);
    while (sfQ.size() != 0 || hbQ.size() != 0 || hbBusy || sfValid) begin
      @(posedge clk);
      cnt++;
      if (cnt > limit) begin
        stopOnError("timeout while waiting for the expected words to drain");
      end
    end
  endtask

  ////////////////////
  // model and stimulus
  ////////////////////

  // failed assertions of the bound checker
  always @(posedge clk) begin
    if (fpgaSerializer_inst.fpgaSerializer_sva_inst.failCount != 0) begin
      stopOnError("an assertion on the pc port handshake failed");
    end
  end

  always @(posedge clk) begin
    sfGot = 1'b0;
    hbGot = 1'b0;
    if (!rst) begin
      // record accepted this edge
      if (sfValid && sfReady) begin
        sfQ.push_back(makeWord(pcLinkPkg::SF_CODE, sfRecord[19:0]));
        sfQ.push_back(makeWord(pcLinkPkg::SF_CODE, {3'b000, sfRecord[36:20]}));
        sfSent++;
      end
      // pulse captured this edge with the low half first
      if (hbPulse) begin
        hbQ.push_back(makeWord(pcLinkPkg::HB_LSB_CODE, timeElapsed[19:0]));
        hbQ.push_back(makeWord(pcLinkPkg::HB_MSB_CODE, timeElapsed[39:20]));
        hbSent++;
      end
      if (pcValid && pcReady) begin
        routeWord(pcWord);
      end
      // starvation per source
      sfWait = (sfQ.size() > 0 && !sfGot) ? sfWait + 1 : 0;
      hbWait = (hbQ.size() > 0 && !hbGot) ? hbWait + 1 : 0;
      if (sfWait > 400) begin
        stopOnError("spike filter words waited more than 400 cycles");
      end
      if (hbWait > 400) begin
        stopOnError("heartbeat words waited more than 400 cycles");
      end
    end
    if (rst) begin
      sfValid <= 1'b0;
      hbPulse <= 1'b0;
      pcReady <= 1'b0;
    end else begin
      // about 60 percent ready
      if (readyRandom) begin
        rVal = randBits(5);
        pcReady <= (rVal[4:0] < 5'd19);
      end else begin
        pcReady <= 1'b1;
      end
      // new record only once the old one is gone
      if (!sfValid || sfReady) begin
        rVal = randBits(2);
        if (sfEnable && rVal[1:0] != 2'b00) begin
          rVal = randBits(37);
          sfRecord <= rVal[36:0];
          sfValid  <= 1'b1;
        end else begin
          sfValid <= 1'b0;
        end
      end
      rVal = randBits(48);
      timeElapsed <= rVal[47:0];
      hbPulse <= 1'b0;
      // next pulse after the previous high half and a random gap
      if (hbEnable && !hbBusy) begin
        if (hbGap == 0) begin
          hbPulse <= 1'b1;
          hbBusy = 1'b1;
          rVal   = randBits(4);
          hbGap  = rVal[3:0];
        end else begin
          hbGap--;
        end
      end
    end
  end

  ////////////////////
  // test sequence
  ////////////////////

  initial begin
    int i;
    clk = 1'b0;
    rst = 1'b1;
    hbPulse = 1'b0;
    timeElapsed = '0;
    sfRecord = '0;
    sfValid = 1'b0;
    pcReady = 1'b0;
    lfsrState = 32'd75087;
    sfEnable = 1'b0;
    hbEnable = 1'b0;
    readyRandom = 1'b0;
    hbBusy = 1'b0;
    sfSent = 0;
    hbSent = 0;
    sfWait = 0;
    hbWait = 0;
    hbGap = 0;
    testName = "reset";
    // first edge still shows power up values
    for (i = 0; i < 16; i++) begin
      @(posedge clk);
      if (i > 0) begin
        checkFlag("reset pcValid", 1'b0, pcValid);
        checkFlag("reset sfReady", 1'b1, sfReady);
      end
    end
    rst <= 1'b0;
    for (i = 0; i < 2; i++) begin
      @(posedge clk);
      checkFlag("after reset pcValid", 1'b0, pcValid);
      checkFlag("after reset sfReady", 1'b1, sfReady);
    end
    testName = "spikeOnly";
    sfEnable <= 1'b1;
    waitForCounts(sfSent + 40, 0, 4000);
    sfEnable <= 1'b0;
    waitForDrain(2000);
    testName = "heartbeatOnly";
    hbEnable <= 1'b1;
    waitForCounts(0, hbSent + 12, 4000);
    hbEnable <= 1'b0;
    waitForDrain(2000);
    testName = "interleave";
    sfEnable <= 1'b1;
    hbEnable <= 1'b1;
    waitForCounts(sfSent + 60, hbSent + 20, 8000);
    testName = "backPressure";
    readyRandom <= 1'b1;
    waitForCounts(sfSent + 150, hbSent + 30, 20000);
    sfEnable <= 1'b0;
    hbEnable <= 1'b0;
    waitForDrain(4000);
    // drained so the port must stay quiet
    testName = "quiet";
    readyRandom <= 1'b0;
    for (i = 0; i < 200; i++) begin
      @(posedge clk);
      checkFlag("quiet pcValid", 1'b0, pcValid);
    end
    // assertions of the last edge settle before the verdict
    @(negedge clk);
    if (fpgaSerializer_inst.fpgaSerializer_sva_inst.failCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+.
pcLinkPkg.sv
spikePkg.sv
pulseToChannel.sv
serializer.sv
channelMerge.sv
fpgaSerializer.sv
fpgaSerializer_sva.sv
tb_fpgaSerializer.sv
